/* Bender.yml */
package:
  name: trap_unit

sources:
  - include_dirs:
      - src
    files:
      - src/trap_pkg.sv
      - src/csr_pkg.sv
      - src/trap_csr_if.sv
      - src/cpu_ctrl.sv
      - src/trap_csr.sv
      - src/pc_gen.sv
      - src/trap_unit_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - dv/trap_unit_tb.sv

/* dv/trap_unit_tb.sv */
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module trap_unit_tb;

    localparam int RESET_CYCLES    = 5;
    localparam int DIRECTED_CYCLES = 30;    // run_cycle calls in the directed part
    localparam int RANDOM_CYCLES   = 2000;
    localparam int CYCLE_LIMIT     = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 200;

    logic clk, rst_n, csr_we;
    logic load_hazard_id_ex, load_hazard_ex_mem, control_hazard, bus_wait;
    logic ebreak_en, ecall_en, mret_en, mem_ebreak_en, mem_ecall_en;
    logic irq_external, irq_timer, irq_software, trap_happened;
    logic pc_stall, if_stall, id_stall, ex_stall, mem_stall;
    logic if_flush, id_flush, ex_flush, mem_flush;
    logic [`EXP_WIDTH-1:0]  exp_code, ex_exp_code, mem_exp_code;
    logic [11:0]            csr_addr;
    logic [`PC_WIDTH-1:0]   id_pc, mem_pc, pc, pc_seen;
    logic [`WORD_WIDTH-1:0] csr_wdata, csr_rdata;
    logic                   trap_seen;

    // reference model state
    logic m_mie, m_mpie, m_meie, m_mtie, m_msie, m_meip, m_mtip, m_msip;
    logic [31:0] m_pc, m_mtvec, m_mepc, m_mcause;
    logic [31:0] rand_state = 32'h5407_59e2;
    int error_count = 0;
    int check_count = 0;
    int cycle_count = 0;

    trap_unit_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == CYCLE_LIMIT) begin
            $display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
            $display("** FAIL **");
            $finish;
        end
    end

    // lcg keeping only upper halves since the low bits repeat quickly
    function automatic logic [31:0] rand_word();
        logic [15:0] hi;
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        hi = rand_state[31:16];
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return {hi, rand_state[31:16]};
    endfunction

    function automatic logic [31:0] model_rdata(input logic [11:0] addr);
        logic [31:0] v;
        v = '0;
        case (addr)
            csr_pkg::CSR_MSTATUS: begin
                v[3] = m_mie;
                v[7] = m_mpie;
            end
            csr_pkg::CSR_MIE: begin
                v[3]  = m_msie;
                v[7]  = m_mtie;
                v[11] = m_meie;
            end
            csr_pkg::CSR_MIP: begin
                v[3]  = m_msip;
                v[7]  = m_mtip;
                v[11] = m_meip;
            end
            csr_pkg::CSR_MTVEC:   v = m_mtvec;
            csr_pkg::CSR_MEPC:    v = m_mepc;
            csr_pkg::CSR_MCAUSE:  v = m_mcause;
            default:              v = '0;   // mtval and unmapped
        endcase
        return v;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAILED at %0t: %s, got %h expected %h", $time, msg, actual, expected);
        end
    endtask

    task automatic check_and_update();
        logic int_ext, int_tmr, int_sw, int_any, exc_mem, trap, mret_ok;
        logic dec_exc, ex_exc, hazard;
        logic [30:0] code;
        logic [31:0] target;
        int_ext = m_mie && m_meie && m_meip;
        int_tmr = m_mie && m_mtie && m_mtip;
        int_sw  = m_mie && m_msie && m_msip;
        int_any = int_ext || int_tmr || int_sw;
        exc_mem = (mem_exp_code != trap_pkg::EXP_NONE) || mem_ecall_en || mem_ebreak_en;
        trap    = int_any || exc_mem;
        mret_ok = mret_en && !trap;
        dec_exc = ebreak_en || ecall_en || (exp_code == trap_pkg::EXP_UNDEF_INSN);
        ex_exc  = (ex_exp_code == trap_pkg::EXP_LOAD_MISALIGNED) ||
                  (ex_exp_code == trap_pkg::EXP_STORE_MISALIGNED);
        hazard  = load_hazard_id_ex || load_hazard_ex_mem;
        if (int_ext) code = trap_pkg::MCAUSE_M_EXT_INT;
        else if (int_tmr) code = trap_pkg::MCAUSE_M_TIMER_INT;
        else if (int_sw) code = trap_pkg::MCAUSE_M_SOFT_INT;
        else if (mem_ecall_en) code = trap_pkg::MCAUSE_ECALL_M;
        else if (mem_ebreak_en) code = trap_pkg::MCAUSE_BREAKPOINT;
        else if (mem_exp_code == trap_pkg::EXP_UNDEF_INSN)
            code = trap_pkg::MCAUSE_ILLEGAL_INSN;
        else if (mem_exp_code == trap_pkg::EXP_ALU_OVERFLOW)
            code = trap_pkg::MCAUSE_ALU_OVERFLOW;
        else if (mem_exp_code == trap_pkg::EXP_LOAD_MISALIGNED)
            code = trap_pkg::MCAUSE_LOAD_MISALIGNED;
        else
            code = trap_pkg::MCAUSE_STORE_MISALIGNED;
        target = {m_mtvec[31:2], 2'b00};
        if (m_mtvec[1:0] == csr_pkg::MTVEC_VECTORED) target = target + {code[29:0], 2'b00};

        pc_seen   = pc;
        trap_seen = trap_happened;
        check_value(pc, m_pc, "pc");
        check_value(trap_happened, trap, "trap_happened");
        check_value({pc_stall, if_stall, id_stall, ex_stall, mem_stall},
                    {hazard || bus_wait, hazard || bus_wait, bus_wait, bus_wait, bus_wait},
                    "stall levels");
        check_value({if_flush, id_flush, ex_flush, mem_flush},
                    {control_hazard || dec_exc || ex_exc || trap, hazard || ex_exc || trap,
                     ex_exc || trap, ex_exc || exc_mem}, "flush levels");
        check_value(csr_rdata, model_rdata(csr_addr), "csr_rdata");

        // state after the coming edge
        if (trap) m_pc = target;
        else if (mret_ok) m_pc = m_mepc;
        else if (!(hazard || bus_wait)) m_pc = m_pc + 32'd4;
        if (trap) begin
            m_mpie   = m_mie;
            m_mie    = 1'b0;
            m_mepc   = int_any ? id_pc : mem_pc;
            m_mcause = {int_any, code};
        end else begin
            if (mret_ok) begin
                m_mie  = m_mpie;
                m_mpie = 1'b1;
            end else if (csr_we && csr_addr == csr_pkg::CSR_MSTATUS) begin
                m_mie  = csr_wdata[3];
                m_mpie = csr_wdata[7];
            end
            if (csr_we && csr_addr == csr_pkg::CSR_MEPC) m_mepc = csr_wdata;
            if (csr_we && csr_addr == csr_pkg::CSR_MCAUSE) m_mcause = csr_wdata;
        end
        if (csr_we && csr_addr == csr_pkg::CSR_MIE) begin
            m_meie = csr_wdata[11];
            m_mtie = csr_wdata[7];
            m_msie = csr_wdata[3];
        end
        if (csr_we && csr_addr == csr_pkg::CSR_MTVEC)
            m_mtvec = {csr_wdata[31:2], 1'b0, csr_wdata[0]};
        m_meip = irq_external;
        m_mtip = irq_timer;
        m_msip = irq_software;
    endtask

    task automatic run_cycle();
        @(negedge clk);
        check_and_update();
        @(posedge clk);
    endtask

    // everything idle apart from the pc values and irq lines
    task automatic set_idle();
        {load_hazard_id_ex, load_hazard_ex_mem, control_hazard, bus_wait} <= 4'b0;
        {ebreak_en, ecall_en, mret_en, mem_ebreak_en, mem_ecall_en} <= 5'b0;
        exp_code     <= trap_pkg::EXP_NONE;
        ex_exp_code  <= trap_pkg::EXP_NONE;
        mem_exp_code <= trap_pkg::EXP_NONE;
        csr_we       <= 1'b0;
    endtask

    task automatic set_irq(input logic ext, input logic tmr, input logic sw);
        irq_external <= ext;
        irq_timer    <= tmr;
        irq_software <= sw;
    endtask

    task automatic idle_cycle();
        set_idle();
        run_cycle();
    endtask

    task automatic mret_cycle();
        set_idle();
        mret_en <= 1'b1;
        run_cycle();
    endtask

    task automatic write_csr(input logic [11:0] addr, input logic [31:0] data);
        set_idle();
        csr_we    <= 1'b1;
        csr_addr  <= addr;
        csr_wdata <= data;
        run_cycle();
    endtask

    task automatic read_csr(input logic [11:0] addr, input logic [31:0] expected,
                            input string msg);
        set_idle();
        csr_addr <= addr;
        @(negedge clk);
        check_value(csr_rdata, expected, msg);
        check_and_update();
        @(posedge clk);
    endtask

    task automatic drive_random();
        logic [31:0] a, b, c;
        a = rand_word();
        b = rand_word();
        c = rand_word();
        load_hazard_id_ex  <= (a[1:0] == 2'b00);
        load_hazard_ex_mem <= (a[3:2] == 2'b00);
        control_hazard     <= (a[5:4] == 2'b00);
        bus_wait           <= (a[7:6] == 2'b00);
        ebreak_en          <= (a[11:8] == 4'h0);
        ecall_en           <= (a[15:12] == 4'h0);
        mret_en            <= (a[19:16] == 4'h0);
        mem_ebreak_en      <= (a[25:20] == 6'h0);   // mem stage traps kept rare
        mem_ecall_en       <= (a[31:26] == 6'h0);
        exp_code           <= b[2:0] % 5;
        ex_exp_code        <= b[5:3] % 5;
        mem_exp_code       <= (b[11:6] == 6'h0) ? 3'd1 + b[13:12] : 3'd0;
        set_irq(b[17:14] == 4'h0, b[21:18] == 4'h0, b[25:22] == 4'h0);
        csr_we             <= (b[29:26] == 4'h0);
        case (c[2:0])
            3'd0: csr_addr <= csr_pkg::CSR_MSTATUS;
            3'd1: csr_addr <= csr_pkg::CSR_MIE;
            3'd2: csr_addr <= csr_pkg::CSR_MTVEC;
            3'd3: csr_addr <= csr_pkg::CSR_MEPC;
            3'd4: csr_addr <= csr_pkg::CSR_MCAUSE;
            3'd5: csr_addr <= csr_pkg::CSR_MTVAL;
            3'd6: csr_addr <= csr_pkg::CSR_MIP;
            default: csr_addr <= 12'h7C0;   // unmapped
        endcase
        id_pc     <= {16'h0, c[31:18], 2'b00};
        mem_pc    <= {16'h0, c[17:4], 2'b00};
        csr_wdata <= rand_word();
    endtask

    initial begin
        rst_n = 1'b0;
        {load_hazard_id_ex, load_hazard_ex_mem, control_hazard, bus_wait} = 4'b0;
        {ebreak_en, ecall_en, mret_en, mem_ebreak_en, mem_ecall_en} = 5'b0;
        {irq_external, irq_timer, irq_software, csr_we} = 4'b0;
        exp_code = '0;
        ex_exp_code = '0;
        mem_exp_code = '0;
        id_pc = '0;
        mem_pc = '0;
        csr_addr = '0;
        csr_wdata = '0;
        {m_mie, m_mpie, m_meie, m_mtie, m_msie, m_meip, m_mtip, m_msip} = 8'b0;
        m_pc = `RESET_PC;
        m_mtvec = `RESET_MTVEC;
        m_mepc = '0;
        m_mcause = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        read_csr(csr_pkg::CSR_MTVEC, `RESET_MTVEC, "mtvec after reset");
        check_value(pc_seen, `RESET_PC, "pc after reset");
        read_csr(csr_pkg::CSR_MSTATUS, 32'h0, "mstatus after reset");
        set_idle();
        load_hazard_id_ex <= 1'b1;
        run_cycle();
        set_idle();
        bus_wait <= 1'b1;
        run_cycle();

        // load misaligned in mem, store misaligned in ex
        set_idle();
        mem_pc       <= 32'h0000_2000;
        id_pc        <= 32'h0000_2008;
        mem_exp_code <= trap_pkg::EXP_LOAD_MISALIGNED;
        ex_exp_code  <= trap_pkg::EXP_STORE_MISALIGNED;
        run_cycle();
        check_value(trap_seen, 1'b1, "mem exception trap");
        read_csr(csr_pkg::CSR_MEPC, 32'h0000_2000, "mepc after load misaligned");
        check_value(pc_seen, `RESET_MTVEC, "pc at direct trap vector");
        read_csr(csr_pkg::CSR_MCAUSE, 32'd4, "mcause load misaligned");
        read_csr(csr_pkg::CSR_MSTATUS, 32'h0, "mstatus after exception");
        set_idle();
        mem_ecall_en  <= 1'b1;
        mem_ebreak_en <= 1'b1;
        mem_exp_code  <= trap_pkg::EXP_ALU_OVERFLOW;
        run_cycle();
        read_csr(csr_pkg::CSR_MCAUSE, 32'd11, "ecall outranks ebreak and overflow");

        // interrupts masked first and then enabled
        write_csr(csr_pkg::CSR_MIE, 32'h0000_0888);
        set_irq(1'b1, 1'b1, 1'b1);
        id_pc <= 32'h0000_3000;
        idle_cycle();
        idle_cycle();
        check_value(trap_seen, 1'b0, "no trap with mstatus.mie clear");
        write_csr(csr_pkg::CSR_MSTATUS, 32'h0000_0008);
        idle_cycle();
        check_value(trap_seen, 1'b1, "external interrupt taken");
        set_irq(1'b0, 1'b1, 1'b1);
        read_csr(csr_pkg::CSR_MCAUSE, 32'h8000_000B, "mcause external");
        read_csr(csr_pkg::CSR_MEPC, 32'h0000_3000, "mepc after interrupt");
        read_csr(csr_pkg::CSR_MSTATUS, 32'h0000_0080, "mstatus after interrupt");
        mret_cycle();
        read_csr(csr_pkg::CSR_MSTATUS, 32'h0000_0088, "mstatus after mret");
        check_value(pc_seen, 32'h0000_3000, "pc after mret");
        check_value(trap_seen, 1'b1, "timer interrupt after mret");
        set_irq(1'b0, 1'b0, 1'b1);
        read_csr(csr_pkg::CSR_MCAUSE, 32'h8000_0007, "mcause timer");
        mret_cycle();
        set_irq(1'b0, 1'b0, 1'b0);
        idle_cycle();
        check_value(trap_seen, 1'b1, "software interrupt after mret");
        read_csr(csr_pkg::CSR_MCAUSE, 32'h8000_0003, "mcause software");

        // vectored mode
        mret_cycle();
        write_csr(csr_pkg::CSR_MTVEC, 32'h0000_0201);
        set_irq(1'b0, 1'b1, 1'b0);
        idle_cycle();
        set_irq(1'b0, 1'b0, 1'b0);
        idle_cycle();
        read_csr(csr_pkg::CSR_MCAUSE, 32'h8000_0007, "mcause vectored timer");
        check_value(pc_seen, 32'h0000_021C, "vectored timer target");
        mret_cycle();

        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            drive_random();
            run_cycle();
        end

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+src
src/trap_pkg.sv
src/csr_pkg.sv
src/trap_csr_if.sv
src/cpu_ctrl.sv
src/trap_csr.sv
src/pc_gen.sv
src/trap_unit_top.sv
dv/trap_unit_tb.sv

/* src/cpu_cfg.svh */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

`define PC_WIDTH    32
`define WORD_WIDTH  32
`define EXP_WIDTH   3               // pipeline exception code

`define RESET_PC    32'h0000_0000
`define RESET_MTVEC 32'h0000_0100   // direct mode with base 0x100

`endif

/* src/cpu_ctrl.sv */
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module cpu_ctrl (
    input  logic [`PC_WIDTH-1:0]    id_pc,
    input  logic [`PC_WIDTH-1:0]    mem_pc,
    input  logic                    load_hazard_id_ex,
    input  logic                    load_hazard_ex_mem,
    input  logic                    control_hazard,
    input  logic                    bus_wait,           // ahb wait level
    input  trap_pkg::exp_code_e     exp_code,           // from decoder
    input  trap_pkg::exp_code_e     ex_exp_code,        // from mem ctrl in ex
    input  trap_pkg::exp_code_e     mem_exp_code,
    input  logic                    ebreak_en,
    input  logic                    ecall_en,
    input  logic                    mret_en,
    input  logic                    mem_ebreak_en,
    input  logic                    mem_ecall_en,
    trap_csr_if.ctrl                csr,
    output logic                    trap_happened,
    output logic                    mret_taken,
    output logic [`PC_WIDTH-1:0]    ctrl_pc,
    output logic                    pc_stall,
    output logic                    if_stall,
    output logic                    id_stall,
    output logic                    ex_stall,
    output logic                    mem_stall,
    output logic                    if_flush,
    output logic                    id_flush,
    output logic                    ex_flush,
    output logic                    mem_flush
);

    logic                   int_external;
    logic                   int_timer;
    logic                   int_software;
    logic                   interrupt_en;
    logic                   exception_mem_en;
    logic                   exp_in_decoder;
    logic                   exp_in_ex;
    logic [30:0]            cause_code;
    logic [`PC_WIDTH-1:0]   trap_base;
    logic [`PC_WIDTH-1:0]   trap_target;

    assign int_external = csr.mstatus_mie && csr.mie_meie && csr.mip_meip;
    assign int_timer    = csr.mstatus_mie && csr.mie_mtie && csr.mip_mtip;
    assign int_software = csr.mstatus_mie && csr.mie_msie && csr.mip_msip;
    assign interrupt_en = int_external || int_timer || int_software;

    assign exception_mem_en = (mem_exp_code != trap_pkg::EXP_NONE) ||
                              mem_ecall_en || mem_ebreak_en;
    assign trap_happened    = interrupt_en || exception_mem_en;
    assign mret_taken       = mret_en && !trap_happened;    // trap wins

    assign exp_in_decoder = ebreak_en || ecall_en || (exp_code == trap_pkg::EXP_UNDEF_INSN);
    assign exp_in_ex      = (ex_exp_code == trap_pkg::EXP_LOAD_MISALIGNED) ||
                            (ex_exp_code == trap_pkg::EXP_STORE_MISALIGNED);

    // interrupts first, then the ranked mem stage exceptions
    always_comb begin
        cause_code = 31'd0;
        if (int_external) begin
            cause_code = trap_pkg::MCAUSE_M_EXT_INT;
        end else if (int_timer) begin
            cause_code = trap_pkg::MCAUSE_M_TIMER_INT;
        end else if (int_software) begin
            cause_code = trap_pkg::MCAUSE_M_SOFT_INT;
        end else if (mem_ecall_en) begin
            cause_code = trap_pkg::MCAUSE_ECALL_M;
        end else if (mem_ebreak_en) begin
            cause_code = trap_pkg::MCAUSE_BREAKPOINT;
        end else if (mem_exp_code == trap_pkg::EXP_UNDEF_INSN) begin
            cause_code = trap_pkg::MCAUSE_ILLEGAL_INSN;
        end else if (mem_exp_code == trap_pkg::EXP_ALU_OVERFLOW) begin
            cause_code = trap_pkg::MCAUSE_ALU_OVERFLOW;
        end else if (mem_exp_code == trap_pkg::EXP_LOAD_MISALIGNED) begin
            cause_code = trap_pkg::MCAUSE_LOAD_MISALIGNED;
        end else if (mem_exp_code == trap_pkg::EXP_STORE_MISALIGNED) begin
            cause_code = trap_pkg::MCAUSE_STORE_MISALIGNED;
        end
    end

    assign trap_base   = {csr.mtvec_base, 2'b00};
    assign trap_target = (csr.mtvec_mode == csr_pkg::MTVEC_VECTORED) ?
                         trap_base + {cause_code[`PC_WIDTH-3:0], 2'b00} : trap_base;

    always_comb begin
        csr.mie_clear_en     = 1'b0;
        csr.mie_set_en       = 1'b0;
        csr.mepc_set_en      = 1'b0;
        csr.mepc_set_pc      = '0;
        csr.mcause_set_en    = 1'b0;
        csr.mcause_set_cause = '0;
        csr.mtval_set_en     = 1'b0;    // mtval kept at zero
        csr.mtval_set_tval   = '0;
        ctrl_pc              = '0;
        if (trap_happened) begin
            csr.mie_clear_en     = 1'b1;
            csr.mepc_set_en      = 1'b1;
            csr.mepc_set_pc      = interrupt_en ? id_pc : mem_pc;   // sw skips ecall itself
            csr.mcause_set_en    = 1'b1;
            csr.mcause_set_cause = {interrupt_en, cause_code};
            ctrl_pc              = trap_target;
        end else if (mret_en) begin
            csr.mie_set_en = 1'b1;
            ctrl_pc        = csr.mepc;
        end
    end

    assign pc_stall  = load_hazard_id_ex || load_hazard_ex_mem || bus_wait;
    assign if_stall  = load_hazard_id_ex || load_hazard_ex_mem || bus_wait;
    assign id_stall  = bus_wait;
    assign ex_stall  = bus_wait;
    assign mem_stall = bus_wait;

    assign if_flush  = control_hazard || exp_in_decoder || exp_in_ex || trap_happened;
    assign id_flush  = load_hazard_id_ex || load_hazard_ex_mem || exp_in_ex || trap_happened;
    assign ex_flush  = exp_in_ex || trap_happened;
    assign mem_flush = exp_in_ex || exception_mem_en;   // interrupt lets mem retire

endmodule

/* src/csr_pkg.sv */
package csr_pkg;

    // machine trap CSR addresses
    typedef enum logic [11:0] {
        CSR_MSTATUS = 12'h300,
        CSR_MIE     = 12'h304,
        CSR_MTVEC   = 12'h305,
        CSR_MEPC    = 12'h341,
        CSR_MCAUSE  = 12'h342,
        CSR_MTVAL   = 12'h343,
        CSR_MIP     = 12'h344
    } csr_addr_e;

    typedef enum logic [1:0] {
        MTVEC_DIRECT   = 2'd0,
        MTVEC_VECTORED = 2'd1      // base + 4 * cause
    } mtvec_mode_e;

endpackage

/* src/pc_gen.sv */
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module pc_gen (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    trap_happened,
    input  logic                    mret_taken,
    input  logic                    pc_stall,
    input  logic [`PC_WIDTH-1:0]    ctrl_pc,
    output logic [`PC_WIDTH-1:0]    pc
);

    localparam logic [`PC_WIDTH-1:0] PC_STEP = 4;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `RESET_PC;
        end else if (trap_happened || mret_taken) begin
            pc <= ctrl_pc;              // redirect beats stall
        end else if (!pc_stall) begin
            pc <= pc + PC_STEP;
        end
    end

endmodule

/* src/trap_csr.sv */
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module trap_csr (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        irq_external,
    input  logic                        irq_timer,
    input  logic                        irq_software,
    input  logic                        csr_we,
    input  csr_pkg::csr_addr_e          csr_addr,
    input  logic [`WORD_WIDTH-1:0]      csr_wdata,
    output logic [`WORD_WIDTH-1:0]      csr_rdata,
    trap_csr_if.csr                     csr
);

    localparam logic [`WORD_WIDTH-1:0] RESET_MTVEC_VAL = `RESET_MTVEC;

    logic [`WORD_WIDTH-1:0] mcause;
    logic [`WORD_WIDTH-1:0] mtval;
    logic                   wr_mstatus;
    logic                   wr_mie;
    logic                   wr_mtvec;
    logic                   wr_mepc;
    logic                   wr_mcause;

    assign wr_mstatus = csr_we && (csr_addr == csr_pkg::CSR_MSTATUS);
    assign wr_mie     = csr_we && (csr_addr == csr_pkg::CSR_MIE);
    assign wr_mtvec   = csr_we && (csr_addr == csr_pkg::CSR_MTVEC);
    assign wr_mepc    = csr_we && (csr_addr == csr_pkg::CSR_MEPC);
    assign wr_mcause  = csr_we && (csr_addr == csr_pkg::CSR_MCAUSE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            csr.mstatus_mie  <= 1'b0;
            csr.mstatus_mpie <= 1'b0;
            csr.mie_meie     <= 1'b0;
            csr.mie_mtie     <= 1'b0;
            csr.mie_msie     <= 1'b0;
            csr.mip_meip     <= 1'b0;
            csr.mip_mtip     <= 1'b0;
            csr.mip_msip     <= 1'b0;
            csr.mtvec_base   <= RESET_MTVEC_VAL[`WORD_WIDTH-1:2];
            csr.mtvec_mode   <= csr_pkg::MTVEC_DIRECT;
            csr.mepc         <= '0;
            mcause           <= '0;
            mtval            <= '0;
        end else begin
            csr.mip_meip <= irq_external;   // pending follows the lines
            csr.mip_mtip <= irq_timer;
            csr.mip_msip <= irq_software;

            if (csr.mie_clear_en) begin
                csr.mstatus_mpie <= csr.mstatus_mie;
                csr.mstatus_mie  <= 1'b0;
            end else if (csr.mie_set_en) begin
                csr.mstatus_mie  <= csr.mstatus_mpie;
                csr.mstatus_mpie <= 1'b1;
            end else if (wr_mstatus) begin
                csr.mstatus_mie  <= csr_wdata[3];
                csr.mstatus_mpie <= csr_wdata[7];
            end

            if (wr_mie) begin
                csr.mie_meie <= csr_wdata[11];
                csr.mie_mtie <= csr_wdata[7];
                csr.mie_msie <= csr_wdata[3];
            end

            if (wr_mtvec) begin
                csr.mtvec_base <= csr_wdata[`WORD_WIDTH-1:2];
                csr.mtvec_mode <= csr_wdata[0] ? csr_pkg::MTVEC_VECTORED :
                                                 csr_pkg::MTVEC_DIRECT;    // mode 2, 3 unused
            end

            if (csr.mepc_set_en) begin
                csr.mepc <= csr.mepc_set_pc;
            end else if (wr_mepc) begin
                csr.mepc <= csr_wdata;
            end

            if (csr.mcause_set_en) begin
                mcause <= csr.mcause_set_cause;
            end else if (wr_mcause) begin
                mcause <= csr_wdata;
            end

            if (csr.mtval_set_en) begin
                mtval <= csr.mtval_set_tval;
            end
        end
    end

    always_comb begin
        case (csr_addr)
            csr_pkg::CSR_MSTATUS: csr_rdata = {24'd0, csr.mstatus_mpie, 3'd0,
                                               csr.mstatus_mie, 3'd0};
            csr_pkg::CSR_MIE:     csr_rdata = {20'd0, csr.mie_meie, 3'd0, csr.mie_mtie,
                                               3'd0, csr.mie_msie, 3'd0};
            csr_pkg::CSR_MIP:     csr_rdata = {20'd0, csr.mip_meip, 3'd0, csr.mip_mtip,
                                               3'd0, csr.mip_msip, 3'd0};
            csr_pkg::CSR_MTVEC:   csr_rdata = {csr.mtvec_base, csr.mtvec_mode};
            csr_pkg::CSR_MEPC:    csr_rdata = csr.mepc;
            csr_pkg::CSR_MCAUSE:  csr_rdata = mcause;
            csr_pkg::CSR_MTVAL:   csr_rdata = mtval;
            default:              csr_rdata = '0;  // unmapped
        endcase
    end

endmodule

/* src/trap_csr_if.sv */
`timescale 1ns/100ps
`include "cpu_cfg.svh"

interface trap_csr_if;

    logic                     mstatus_mie;
    logic                     mstatus_mpie;
    logic                     mie_meie;
    logic                     mie_mtie;
    logic                     mie_msie;
    logic                     mip_meip;
    logic                     mip_mtip;
    logic                     mip_msip;
    logic [29:0]              mtvec_base;
    csr_pkg::mtvec_mode_e     mtvec_mode;
    logic [`PC_WIDTH-1:0]     mepc;

    logic                     mie_clear_en;     // trap entry
    logic                     mie_set_en;       // mret
    logic                     mepc_set_en;
    logic [`PC_WIDTH-1:0]     mepc_set_pc;
    logic                     mcause_set_en;
    logic [`WORD_WIDTH-1:0]   mcause_set_cause;
    logic                     mtval_set_en;
    logic [`WORD_WIDTH-1:0]   mtval_set_tval;

    modport ctrl (
        input  mstatus_mie, mstatus_mpie,
        input  mie_meie, mie_mtie, mie_msie,
        input  mip_meip, mip_mtip, mip_msip,
        input  mtvec_base, mtvec_mode, mepc,
        output mie_clear_en, mie_set_en,
        output mepc_set_en, mepc_set_pc,
        output mcause_set_en, mcause_set_cause,
        output mtval_set_en, mtval_set_tval
    );

    modport csr (
        output mstatus_mie, mstatus_mpie,
        output mie_meie, mie_mtie, mie_msie,
        output mip_meip, mip_mtip, mip_msip,
        output mtvec_base, mtvec_mode, mepc,
        input  mie_clear_en, mie_set_en,
        input  mepc_set_en, mepc_set_pc,
        input  mcause_set_en, mcause_set_cause,
        input  mtval_set_en, mtval_set_tval
    );

endinterface

/* src/trap_pkg.sv */
`include "cpu_cfg.svh"

package trap_pkg;

    // exception code travelling down the pipeline stages
    typedef enum logic [`EXP_WIDTH-1:0] {
        EXP_NONE             = 0,
        EXP_UNDEF_INSN       = 1,
        EXP_ALU_OVERFLOW     = 2,
        EXP_LOAD_MISALIGNED  = 3,
        EXP_STORE_MISALIGNED = 4
    } exp_code_e;

    // mcause exception codes with bit 31 clear
    typedef enum logic [30:0] {
        MCAUSE_ILLEGAL_INSN     = 31'd2,
        MCAUSE_BREAKPOINT       = 31'd3,
        MCAUSE_LOAD_MISALIGNED  = 31'd4,
        MCAUSE_STORE_MISALIGNED = 31'd6,
        MCAUSE_ECALL_M          = 31'd11,
        MCAUSE_ALU_OVERFLOW     = 31'd24    // custom
    } mcause_code_e;

    // interrupt cause codes marked by bit 31 in mcause
    typedef enum logic [30:0] {
        MCAUSE_M_SOFT_INT  = 31'd3,
        MCAUSE_M_TIMER_INT = 31'd7,
        MCAUSE_M_EXT_INT   = 31'd11
    } mcause_irq_e;

endpackage

/* src/trap_unit_top.sv */
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module trap_unit_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`PC_WIDTH-1:0]        id_pc,
    input  logic [`PC_WIDTH-1:0]        mem_pc,
    input  logic                        load_hazard_id_ex,
    input  logic                        load_hazard_ex_mem,
    input  logic                        control_hazard,
    input  logic                        bus_wait,
    input  logic [`EXP_WIDTH-1:0]       exp_code,
    input  logic [`EXP_WIDTH-1:0]       ex_exp_code,
    input  logic [`EXP_WIDTH-1:0]       mem_exp_code,
    input  logic                        ebreak_en,
    input  logic                        ecall_en,
    input  logic                        mret_en,
    input  logic                        mem_ebreak_en,
    input  logic                        mem_ecall_en,
    input  logic                        irq_external,
    input  logic                        irq_timer,
    input  logic                        irq_software,
    input  logic                        csr_we,
    input  logic [11:0]                 csr_addr,
    input  logic [`WORD_WIDTH-1:0]      csr_wdata,
    output logic [`WORD_WIDTH-1:0]      csr_rdata,
    output logic [`PC_WIDTH-1:0]        pc,
    output logic                        trap_happened,
    output logic                        pc_stall,
    output logic                        if_stall,
    output logic                        id_stall,
    output logic                        ex_stall,
    output logic                        mem_stall,
    output logic                        if_flush,
    output logic                        id_flush,
    output logic                        ex_flush,
    output logic                        mem_flush
);

    logic                   mret_taken;
    logic [`PC_WIDTH-1:0]   ctrl_pc;

    trap_csr_if csr_bus ();

    pc_gen u_pc_gen (
        .clk           (clk),
        .rst_n         (rst_n),
        .trap_happened (trap_happened),
        .mret_taken    (mret_taken),
        .pc_stall      (pc_stall),
        .ctrl_pc       (ctrl_pc),
        .pc            (pc)
    );

    cpu_ctrl u_cpu_ctrl (
        .id_pc              (id_pc),
        .mem_pc             (mem_pc),
        .load_hazard_id_ex  (load_hazard_id_ex),
        .load_hazard_ex_mem (load_hazard_ex_mem),
        .control_hazard     (control_hazard),
        .bus_wait           (bus_wait),
        .exp_code           (trap_pkg::exp_code_e'(exp_code)),
        .ex_exp_code        (trap_pkg::exp_code_e'(ex_exp_code)),
        .mem_exp_code       (trap_pkg::exp_code_e'(mem_exp_code)),
        .ebreak_en          (ebreak_en),
        .ecall_en           (ecall_en),
        .mret_en            (mret_en),
        .mem_ebreak_en      (mem_ebreak_en),
        .mem_ecall_en       (mem_ecall_en),
        .csr                (csr_bus.ctrl),
        .trap_happened      (trap_happened),
        .mret_taken         (mret_taken),
        .ctrl_pc            (ctrl_pc),
        .pc_stall           (pc_stall),
        .if_stall           (if_stall),
        .id_stall           (id_stall),
        .ex_stall           (ex_stall),
        .mem_stall          (mem_stall),
        .if_flush           (if_flush),
        .id_flush           (id_flush),
        .ex_flush           (ex_flush),
        .mem_flush          (mem_flush)
    );

    trap_csr u_trap_csr (
        .clk          (clk),
        .rst_n        (rst_n),
        .irq_external (irq_external),
        .irq_timer    (irq_timer),
        .irq_software (irq_software),
        .csr_we       (csr_we),
        .csr_addr     (csr_pkg::csr_addr_e'(csr_addr)),   // unmapped reads zero
        .csr_wdata    (csr_wdata),
        .csr_rdata    (csr_rdata),
        .csr          (csr_bus.csr)
    );

endmodule
